// File: bench/tb_program.svh
// Program image from reset_pc with four consecutive words per line
localparam int prog_len  = 35;
localparam int trace_len = 23;
localparam int store_len = 1;

logic [31:0] prog_words [prog_len] = '{
    32'h02bf_f404, 32'h0281_fc05, 32'h1500_0026, 32'h0288_d0c6,  // Operand setup
    32'h0080_1487, 32'h0081_1488, 32'h0082_1489, 32'h0082_948a,  // add sub slt sltu
    32'h0084_18ab, 32'h0084_94cc, 32'h0085_14cd, 32'h0085_90ce,  // nor and or xor
    32'h0040_90cf, 32'h0044_a0d0, 32'h0048_a0d1, 32'h1400_0212,  // Shifts, data base
    32'h2980_2246, 32'h2880_2253, 32'h5800_0c85, 32'h5c00_0884,  // st ld beq bne
    32'h0280_0414, 32'h5800_08a5, 32'h0281_9815, 32'h5c00_0885,  // beq taken over r21
    32'h0281_dc15, 32'h5000_0800, 32'h0281_5415, 32'h5400_0c00,  // b over r21, bl
    32'h0281_1015, 32'h5000_0c00, 32'h0280_8817, 32'h4c00_0438,  // Subroutine, jirl
    32'h0080_14a0, 32'h0085_0019, 32'h5000_0000                  // r0 write, spin
};

// Expected write-backs in order as PC, register number and value
logic [68:0] trace_rows [trace_len] = '{
    {32'h1c00_0000, 5'd4,  32'hffff_fffd},
    {32'h1c00_0004, 5'd5,  32'h0000_007f},
    {32'h1c00_0008, 5'd6,  32'h8000_1000},
    {32'h1c00_000c, 5'd6,  32'h8000_1234},
    {32'h1c00_0010, 5'd7,  32'h0000_007c},
    {32'h1c00_0014, 5'd8,  32'hffff_ff7e},
    {32'h1c00_0018, 5'd9,  32'h0000_0001},  // Signed compare with -3
    {32'h1c00_001c, 5'd10, 32'h0000_0000},  // Unsigned compare with -3
    {32'h1c00_0020, 5'd11, 32'h7fff_ed80},
    {32'h1c00_0024, 5'd12, 32'h0000_0034},
    {32'h1c00_0028, 5'd13, 32'h8000_127f},
    {32'h1c00_002c, 5'd14, 32'h7fff_edc9},
    {32'h1c00_0030, 5'd15, 32'h0001_2340},
    {32'h1c00_0034, 5'd16, 32'h0080_0012},
    {32'h1c00_0038, 5'd17, 32'hff80_0012},
    {32'h1c00_003c, 5'd18, 32'h0001_0000},
    {32'h1c00_0044, 5'd19, 32'h8000_1234},  // Load of the stored word
    {32'h1c00_0050, 5'd20, 32'h0000_0001},  // Skipped if either branch before it is taken
    {32'h1c00_006c, 5'd1,  32'h1c00_0070},  // bl link
    {32'h1c00_0078, 5'd23, 32'h0000_0022},
    {32'h1c00_007c, 5'd24, 32'h1c00_0080},  // jirl link that returns to 1c000074
    {32'h1c00_0080, 5'd0,  32'h0000_00fe},
    {32'h1c00_0084, 5'd25, 32'h0000_0000}   // r0 still reads zero
};

// Expected stores as address and data
logic [63:0] store_rows [store_len] = '{
    {32'h0001_0008, 32'h8000_1234}
};

// File: bench/tb_cpu_top.sv
module tb_cpu_top
    import cpu_pkg::*;
();
    logic        clk;
    logic        reset;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    logic [31:0] inst_offset;
    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    int          value_errors;
    int          other_errors;
    int          store_count;

`include "tb_program.svh"

    cpu_top cpu_top_i (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #10 clk = ~clk;

    // --------------------
    // SRAM models
    assign inst_offset     = inst_sram_addr - reset_pc;
    assign inst_sram_rdata = imem[inst_offset[7:2]];
    assign data_sram_rdata = dmem[data_sram_addr[9:2]];

    always @(posedge clk) begin
        if (data_sram_we)
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            value_errors++;
        end
    endtask

    // Every store strobe is matched against the next store row
    always @(negedge clk) begin
        if (!reset && data_sram_we) begin
            if (store_count < store_len) begin
                check_value("data_sram_addr", data_sram_addr, store_rows[store_count][63:32]);
                check_value("data_sram_wdata", data_sram_wdata, store_rows[store_count][31:0]);
            end else begin
                $display("Unexpected store to address %h", data_sram_addr);
                other_errors++;
            end
            store_count++;
        end
    end

    // --------------------
    // Main sequence
    initial begin
        logic [31:0] exp_pc;
        logic [4:0]  exp_wnum;
        logic [31:0] exp_wdata;
        int          wait_cycles;
        logic        timed_out;

        clk          = 1'b0;
        reset        = 1'b1;
        value_errors = 0;
        other_errors = 0;
        store_count  = 0;
        timed_out    = 1'b0;
        for (int i = 0; i < 64; i++)
            imem[i] = (i < prog_len) ? prog_words[i] : 32'h0;
        for (int i = 0; i < 256; i++)
            dmem[i] = 32'h5a00_0000 | (i << 12) | (i ^ 8'hc3);  // Word index in two places

        repeat (10) @(posedge clk);
        #1 reset = 1'b0;

        // IF and ID of the first instruction
        for (int c = 0; c < 2; c++) begin
            @(negedge clk);
            if (c == 0)
                check_value("inst_sram_addr", inst_sram_addr, reset_pc);
            check_value("data_sram_we", {31'b0, data_sram_we}, 32'h0);
            check_value("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'h0);
        end

        for (int r = 0; r < trace_len && !timed_out; r++) begin
            {exp_pc, exp_wnum, exp_wdata} = trace_rows[r];
            wait_cycles = 0;
            while (debug_wb_rf_we == 4'h0 && wait_cycles < 50) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (debug_wb_rf_we == 4'h0) begin
                $display("Timed out waiting for write-back %0d from PC %h", r, exp_pc);
                other_errors++;
                timed_out = 1'b1;
            end else begin
                check_value("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'hf);
                check_value("debug_wb_pc", debug_wb_pc, exp_pc);
                check_value("debug_wb_rf_wnum", {27'b0, debug_wb_rf_wnum}, {27'b0, exp_wnum});
                check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wdata);
                @(negedge clk);
            end
        end

        // The program ends in a b-to-self loop, so no further write-back may show up
        if (!timed_out) begin
            wait_cycles = 0;
            while (debug_wb_rf_we == 4'h0 && wait_cycles < 20) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (debug_wb_rf_we != 4'h0) begin
                $display("Unexpected write-back from PC %h", debug_wb_pc);
                other_errors++;
            end
        end
        if (store_count != store_len) begin
            $display("Saw %0d stores where %0d were expected", store_count, store_len);
            other_errors++;
        end

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+bench
src/cpu_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/alu.sv
src/cpu_sequencer.sv
src/cpu_top.sv
bench/tb_cpu_top.sv

// File: src/alu.sv
module alu
    import cpu_pkg::*;
(
    input  alu_op_t         alu_op,
    input  logic [xlen-1:0] alu_src1,
    input  logic [xlen-1:0] alu_src2,
    output logic [xlen-1:0] alu_result
);
    logic            subtract;
    logic [xlen-1:0] adder_b;
    logic [xlen-1:0] sum;
    logic            carry_out;
    logic            less_signed;
    logic            less_unsigned;
    logic [4:0]      shamt;

    // --------------------
    // Shared adder for add, sub and the compares
    assign subtract = alu_op[alu_sub] | alu_op[alu_slt] | alu_op[alu_sltu];
    assign adder_b  = subtract ? ~alu_src2 : alu_src2;
    assign {carry_out, sum} = {1'b0, alu_src1} + {1'b0, adder_b} + {{xlen{1'b0}}, subtract};

    assign less_signed   = (alu_src1[xlen-1] & ~alu_src2[xlen-1])
                         | (~(alu_src1[xlen-1] ^ alu_src2[xlen-1]) & sum[xlen-1]);
    assign less_unsigned = ~carry_out;                  // Borrow out of src1 - src2
    assign shamt         = alu_src2[4:0];

    always_comb begin
        unique case (1'b1)
            alu_op[alu_add]:  alu_result = sum;
            alu_op[alu_sub]:  alu_result = sum;
            alu_op[alu_slt]:  alu_result = {31'b0, less_signed};
            alu_op[alu_sltu]: alu_result = {31'b0, less_unsigned};
            alu_op[alu_and]:  alu_result = alu_src1 & alu_src2;
            alu_op[alu_nor]:  alu_result = ~(alu_src1 | alu_src2);
            alu_op[alu_or]:   alu_result = alu_src1 | alu_src2;
            alu_op[alu_xor]:  alu_result = alu_src1 ^ alu_src2;
            alu_op[alu_sll]:  alu_result = alu_src1 << shamt;
            alu_op[alu_srl]:  alu_result = alu_src1 >> shamt;
            alu_op[alu_sra]:  alu_result = $signed(alu_src1) >>> shamt;
            alu_op[alu_lui]:  alu_result = alu_src2;    // Immediate arrives already shifted
            default:          alu_result = '0;
        endcase
    end

endmodule

// File: src/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

    // --------------------
    // Control states
    typedef enum logic [2:0] {
        idle_fetch = 3'd0,
        decode     = 3'd1,
        execute    = 3'd2,
        memory     = 3'd3,
        writeback  = 3'd4
    } cpu_state_t;

    // --------------------
    // ALU operation vector with exactly one bit set per operation
    typedef logic [11:0] alu_op_t;

    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // --------------------
    // Opcodes sized to the field layout they are matched in
    localparam logic [16:0] op_add_w  = 17'h00100;
    localparam logic [16:0] op_sub_w  = 17'h00102;
    localparam logic [16:0] op_slt    = 17'h00104;
    localparam logic [16:0] op_sltu   = 17'h00105;
    localparam logic [16:0] op_nor    = 17'h00108;
    localparam logic [16:0] op_and    = 17'h00109;
    localparam logic [16:0] op_or     = 17'h0010a;
    localparam logic [16:0] op_xor    = 17'h0010b;
    localparam logic [16:0] op_slli_w = 17'h00081;
    localparam logic [16:0] op_srli_w = 17'h00089;
    localparam logic [16:0] op_srai_w = 17'h00091;
    localparam logic [9:0]  op_addi_w = 10'h00a;
    localparam logic [9:0]  op_ld_w   = 10'h0a2;
    localparam logic [9:0]  op_st_w   = 10'h0a6;
    localparam logic [5:0]  op_jirl   = 6'h13;
    localparam logic [5:0]  op_b      = 6'h14;
    localparam logic [5:0]  op_bl     = 6'h15;
    localparam logic [5:0]  op_beq    = 6'h16;
    localparam logic [5:0]  op_bne    = 6'h17;
    localparam logic [6:0]  op_lu12i  = 7'h0a;

    // --------------------
    // Instruction word viewed through the four layouts
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_3r;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] imm;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_i12;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] imm;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_i16;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] imm;
            logic [4:0]  rd;
        } fmt_i20;
    } inst_word_t;

endpackage

// File: src/cpu_sequencer.sv
module cpu_sequencer
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic [xlen-1:0] inst_sram_rdata,
    input  logic            is_branch_cond,
    input  logic            branch_on_equal,
    input  logic            is_jump_rel,
    input  logic            is_jump_reg,
    input  logic            uses_mem,
    input  logic            is_load,
    input  logic            writes_reg,
    input  logic [xlen-1:0] br_offs,
    input  logic [xlen-1:0] jirl_offs,
    input  logic [xlen-1:0] rj_value,
    input  logic [xlen-1:0] rkd_value,
    input  logic [xlen-1:0] data_sram_rdata,
    output logic [xlen-1:0] pc,
    output inst_word_t      inst,
    output logic            mem_we,
    output logic            rf_we,
    output logic [xlen-1:0] load_data
);
    cpu_state_t      state;
    cpu_state_t      state_next;
    logic [xlen-1:0] seq_pc;
    logic [xlen-1:0] br_target;
    logic [xlen-1:0] target_pc;
    logic [xlen-1:0] npc;
    logic            rj_eq_rd;
    logic            br_taken;

    // --------------------
    // Branch resolution, valid in ID
    assign seq_pc    = pc + 32'd4;
    assign rj_eq_rd  = rj_value == rkd_value;
    assign br_taken  = is_jump_rel | is_jump_reg
                     | (is_branch_cond & (branch_on_equal == rj_eq_rd));
    assign br_target = is_jump_reg ? rj_value + jirl_offs : pc + br_offs;
    assign target_pc = br_taken ? br_target : seq_pc;

    // --------------------
    // Next state
    always_comb begin
        case (state)
            idle_fetch:
                state_next = decode;
            decode: begin
                if (is_branch_cond || (is_jump_rel && !writes_reg))
                    state_next = idle_fetch;            // b, beq, bne finish here
                else
                    state_next = execute;
            end
            execute:
                state_next = uses_mem ? memory : writeback;
            memory:
                state_next = is_load ? writeback : idle_fetch;
            writeback:
                state_next = idle_fetch;
            default:
                state_next = idle_fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle_fetch;
            pc    <= reset_pc;
        end else begin
            state <= state_next;
            // PC holds the current instruction's address until it retires
            if (state_next == idle_fetch)
                pc <= (state == decode) ? target_pc : npc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle_fetch)
            inst <= inst_sram_rdata;
        if (state == decode)
            npc <= target_pc;                           // Jump target kept past the rj overwrite
        if (state == memory)
            load_data <= data_sram_rdata;
    end

    assign mem_we = (state == memory) && uses_mem && !is_load;
    assign rf_we  = (state == writeback) && writes_reg;

endmodule

// File: src/cpu_top.sv
module cpu_top
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    // Instruction SRAM
    output logic [xlen-1:0] inst_sram_addr,
    input  logic [xlen-1:0] inst_sram_rdata,
    // Data SRAM
    output logic            data_sram_we,
    output logic [xlen-1:0] data_sram_addr,
    output logic [xlen-1:0] data_sram_wdata,
    input  logic [xlen-1:0] data_sram_rdata,
    // Write-back trace
    output logic [xlen-1:0] debug_wb_pc,
    output logic [3:0]      debug_wb_rf_we,
    output logic [4:0]      debug_wb_rf_wnum,
    output logic [xlen-1:0] debug_wb_rf_wdata
);
    inst_word_t      inst;
    alu_op_t         alu_op;
    logic [xlen-1:0] pc;
    logic            src1_is_pc;
    logic            src2_is_imm;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] br_offs;
    logic [xlen-1:0] jirl_offs;
    logic [4:0]      rf_raddr1;
    logic [4:0]      rf_raddr2;
    logic [4:0]      dest;
    logic            is_branch_cond;
    logic            branch_on_equal;
    logic            is_jump_rel;
    logic            is_jump_reg;
    logic            uses_mem;
    logic            is_load;
    logic            writes_reg;
    logic [xlen-1:0] rj_value;
    logic [xlen-1:0] rkd_value;
    logic [xlen-1:0] alu_src1;
    logic [xlen-1:0] alu_src2;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] wb_data;
    logic            rf_we;

    cpu_sequencer cpu_sequencer_i (
        .clk             (clk),
        .reset           (reset),
        .inst_sram_rdata (inst_sram_rdata),
        .is_branch_cond  (is_branch_cond),
        .branch_on_equal (branch_on_equal),
        .is_jump_rel     (is_jump_rel),
        .is_jump_reg     (is_jump_reg),
        .uses_mem        (uses_mem),
        .is_load         (is_load),
        .writes_reg      (writes_reg),
        .br_offs         (br_offs),
        .jirl_offs       (jirl_offs),
        .rj_value        (rj_value),
        .rkd_value       (rkd_value),
        .data_sram_rdata (data_sram_rdata),
        .pc              (pc),
        .inst            (inst),
        .mem_we          (data_sram_we),
        .rf_we           (rf_we),
        .load_data       (load_data)
    );

    inst_decoder inst_decoder_i (
        .inst            (inst),
        .alu_op          (alu_op),
        .src1_is_pc      (src1_is_pc),
        .src2_is_imm     (src2_is_imm),
        .imm             (imm),
        .br_offs         (br_offs),
        .jirl_offs       (jirl_offs),
        .rf_raddr1       (rf_raddr1),
        .rf_raddr2       (rf_raddr2),
        .dest            (dest),
        .is_branch_cond  (is_branch_cond),
        .branch_on_equal (branch_on_equal),
        .is_jump_rel     (is_jump_rel),
        .is_jump_reg     (is_jump_reg),
        .uses_mem        (uses_mem),
        .is_load         (is_load),
        .writes_reg      (writes_reg)
    );

    regfile regfile_i (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (dest),
        .wdata  (wb_data),
        .rdata1 (rj_value),
        .rdata2 (rkd_value)
    );

    assign alu_src1 = src1_is_pc ? pc : rj_value;
    assign alu_src2 = src2_is_imm ? imm : rkd_value;

    alu alu_i (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    assign wb_data = is_load ? load_data : alu_result;

    assign inst_sram_addr  = pc;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = rkd_value;                 // Store data comes from rd

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = wb_data;

endmodule

// File: src/inst_decoder.sv
module inst_decoder
    import cpu_pkg::*;
(
    input  inst_word_t      inst,
    output alu_op_t         alu_op,
    output logic            src1_is_pc,
    output logic            src2_is_imm,
    output logic [xlen-1:0] imm,
    output logic [xlen-1:0] br_offs,
    output logic [xlen-1:0] jirl_offs,
    output logic [4:0]      rf_raddr1,
    output logic [4:0]      rf_raddr2,
    output logic [4:0]      dest,
    output logic            is_branch_cond,
    output logic            branch_on_equal,
    output logic            is_jump_rel,
    output logic            is_jump_reg,
    output logic            uses_mem,
    output logic            is_load,
    output logic            writes_reg
);
    logic        inst_add_w;
    logic        inst_sub_w;
    logic        inst_slt;
    logic        inst_sltu;
    logic        inst_nor;
    logic        inst_and;
    logic        inst_or;
    logic        inst_xor;
    logic        inst_slli_w;
    logic        inst_srli_w;
    logic        inst_srai_w;
    logic        inst_addi_w;
    logic        inst_ld_w;
    logic        inst_st_w;
    logic        inst_jirl;
    logic        inst_b;
    logic        inst_bl;
    logic        inst_beq;
    logic        inst_bne;
    logic        inst_lu12i_w;
    logic        is_alu_3r;
    logic        is_shift_imm;
    logic [11:0] si12;
    logic [15:0] si16;
    logic [25:0] si26;

    // --------------------
    // Instruction match
    assign inst_add_w   = inst.fmt_3r.opcode == op_add_w;
    assign inst_sub_w   = inst.fmt_3r.opcode == op_sub_w;
    assign inst_slt     = inst.fmt_3r.opcode == op_slt;
    assign inst_sltu    = inst.fmt_3r.opcode == op_sltu;
    assign inst_nor     = inst.fmt_3r.opcode == op_nor;
    assign inst_and     = inst.fmt_3r.opcode == op_and;
    assign inst_or      = inst.fmt_3r.opcode == op_or;
    assign inst_xor     = inst.fmt_3r.opcode == op_xor;
    assign inst_slli_w  = inst.fmt_3r.opcode == op_slli_w;
    assign inst_srli_w  = inst.fmt_3r.opcode == op_srli_w;
    assign inst_srai_w  = inst.fmt_3r.opcode == op_srai_w;
    assign inst_addi_w  = inst.fmt_i12.opcode == op_addi_w;
    assign inst_ld_w    = inst.fmt_i12.opcode == op_ld_w;
    assign inst_st_w    = inst.fmt_i12.opcode == op_st_w;
    assign inst_jirl    = inst.fmt_i16.opcode == op_jirl;
    assign inst_b       = inst.fmt_i16.opcode == op_b;
    assign inst_bl      = inst.fmt_i16.opcode == op_bl;
    assign inst_beq     = inst.fmt_i16.opcode == op_beq;
    assign inst_bne     = inst.fmt_i16.opcode == op_bne;
    assign inst_lu12i_w = inst.fmt_i20.opcode == op_lu12i;

    assign is_alu_3r    = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                        | inst_nor | inst_and | inst_or | inst_xor;
    assign is_shift_imm = inst_slli_w | inst_srli_w | inst_srai_w;

    assign alu_op[alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                            | inst_jirl | inst_bl;
    assign alu_op[alu_sub]  = inst_sub_w;
    assign alu_op[alu_slt]  = inst_slt;
    assign alu_op[alu_sltu] = inst_sltu;
    assign alu_op[alu_and]  = inst_and;
    assign alu_op[alu_nor]  = inst_nor;
    assign alu_op[alu_or]   = inst_or;
    assign alu_op[alu_xor]  = inst_xor;
    assign alu_op[alu_sll]  = inst_slli_w;
    assign alu_op[alu_srl]  = inst_srli_w;
    assign alu_op[alu_sra]  = inst_srai_w;
    assign alu_op[alu_lui]  = inst_lu12i_w;

    // --------------------
    // Immediates
    assign si12 = inst.fmt_i12.imm;
    assign si16 = inst.fmt_i16.imm;
    assign si26 = {inst.fmt_i16.rj, inst.fmt_i16.rd, inst.fmt_i16.imm}; // Offset split over two fields

    always_comb begin
        if (inst_jirl || inst_bl)
            imm = 32'd4;                                // Link value is PC+4
        else if (inst_lu12i_w)
            imm = {inst.fmt_i20.imm, 12'b0};
        else if (is_shift_imm)
            imm = {27'b0, inst.fmt_3r.rk};              // ui5 sits in the rk slot
        else
            imm = {{20{si12[11]}}, si12};
    end

    assign br_offs   = (inst_b || inst_bl) ? {{4{si26[25]}}, si26, 2'b0}
                                           : {{14{si16[15]}}, si16, 2'b0};
    assign jirl_offs = {{14{si16[15]}}, si16, 2'b0};

    assign src1_is_pc  = inst_jirl | inst_bl;
    assign src2_is_imm = is_shift_imm | inst_addi_w | inst_ld_w | inst_st_w
                       | inst_lu12i_w | inst_jirl | inst_bl;

    assign rf_raddr1 = inst.fmt_3r.rj;
    assign rf_raddr2 = (inst_beq || inst_bne || inst_st_w) ? inst.fmt_3r.rd : inst.fmt_3r.rk;
    assign dest      = inst_bl ? 5'd1 : inst.fmt_3r.rd;

    assign is_branch_cond  = inst_beq | inst_bne;
    assign branch_on_equal = inst_beq;
    assign is_jump_rel     = inst_b | inst_bl;
    assign is_jump_reg     = inst_jirl;
    assign uses_mem        = inst_ld_w | inst_st_w;
    assign is_load         = inst_ld_w;
    assign writes_reg      = is_alu_3r | is_shift_imm | inst_addi_w | inst_lu12i_w
                           | inst_ld_w | inst_jirl | inst_bl;

endmodule

// File: src/regfile.sv
module regfile
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic [4:0]      raddr1,
    input  logic [4:0]      raddr2,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2
);
    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we)
            regs[waddr] <= wdata;                       // r0 may be written but is never read
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule
